// File: rtl/sdram_defs.svh
`ifndef SDRAM_DEFS_SVH
`define SDRAM_DEFS_SVH

// request address is {row, bank, column}
`define ADDR_W 27
`define DATA_W 32

// minimum spacing on the command pins, in cycles
`define WAIT_ACTV 3
`define WAIT_ARSR 15
`define WAIT_OTHER 4

// device read latency after READ on the pins
`define CAS_LAT 2
// latched pulse to read-valid pulse
`define RD_LAT 4

// cycles between refresh strobe toggles
`define REFRESH_PERIOD 200

`endif

// File: rtl/sdram_pkg.sv
`default_nettype none

`include "sdram_defs.svh"

package sdram_pkg;

  // values follow the {ras_n, cas_n, we_n} pin pattern
  typedef enum logic [2:0] {
    NOOP = 3'b111,
    ACTV = 3'b011,
    READ = 3'b101,
    WRTE = 3'b100,
    PRCH = 3'b010,
    ARSR = 3'b001
  } sdram_cmd_e;

  typedef struct packed {
    logic [`ADDR_W-1:0] addr;  // row, bank, column
    logic               we;
    logic [`DATA_W-1:0] wdata;
  } client_req_t;

  typedef struct packed {
    sdram_cmd_e  cmd;
    logic [1:0]  bank;
    logic [12:0] addr;  // row on ACTV, column on READ/WRTE
  } mem_cmd_t;

  typedef struct packed {
    logic               valid;
    logic               id;     // client that issued the read
    logic [`DATA_W-1:0] rdata;
  } rd_resp_t;

endpackage

`default_nettype wire

// File: rtl/sdram_timing.sv
`timescale 1ns/1ns
`default_nettype none

`include "sdram_defs.svh"

module sdram_timing (
  input  wire logic             CLK,
  input  wire logic             RST,
  input  wire logic             change_requested,
  input  wire sdram_pkg::sdram_cmd_e command,
  output logic                  change_possible,
  output sdram_pkg::sdram_cmd_e state,
  output logic                  clock_prch,
  output logic                  page_active
);

  import sdram_pkg::*;

  logic [3:0] wait_cnt;     // cycles left before the next command
  logic       state_is_rw;
  logic       repeat_rw;
  logic       accept;

  // back-to-back read or write needs no spacing
  assign repeat_rw       = state_is_rw && (command == state);
  assign change_possible = (wait_cnt == 4'd0) || repeat_rw;
  assign accept          = change_requested && change_possible;

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      wait_cnt    <= 4'(`WAIT_ARSR - 1);  // full wait before the first command
      state       <= NOOP;
      state_is_rw <= 1'b0;
      clock_prch  <= 1'b0;
      page_active <= 1'b0;
    end
    else
    begin
      clock_prch <= 1'b0;
      if (accept)
      begin
        state       <= command;
        state_is_rw <= (command == READ) || (command == WRTE);
        case (command)
          ACTV:
          begin
            wait_cnt    <= 4'(`WAIT_ACTV - 1);
            page_active <= 1'b1;
          end
          ARSR:
          begin
            wait_cnt <= 4'(`WAIT_ARSR - 1);
          end
          PRCH:
          begin
            // PRCH reaches the pins one cycle late, so one more cycle here
            wait_cnt    <= 4'(`WAIT_OTHER);
            clock_prch  <= 1'b1;
            page_active <= 1'b0;
          end
          default:
          begin
            wait_cnt <= 4'(`WAIT_OTHER - 1);
          end
        endcase
      end
      else if (wait_cnt != 4'd0)
      begin
        wait_cnt <= wait_cnt - 4'd1;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/sdram_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

`include "sdram_defs.svh"

module sdram_sequencer (
  input  wire logic                   CLK,
  input  wire logic                   RST,
  input  wire logic                   do_act,
  input  wire sdram_pkg::client_req_t sel_req,
  input  wire logic                   refresh_strobe,
  input  wire logic                   change_possible,
  input  wire logic                   clock_prch,
  input  wire logic                   page_active,
  output sdram_pkg::sdram_cmd_e       command,
  output logic                        change_requested,
  output logic                        seq_idle,
  output logic                        latched,
  output sdram_pkg::mem_cmd_t         mem_cmd
);

  import sdram_pkg::*;

  localparam int COL_W  = 13;
  localparam int BANK_W = 2;
  localparam int ROW_W  = `ADDR_W - COL_W - BANK_W;

  sdram_cmd_e                cmd_list [3];  // head is the command being asked for
  logic [1:0]                cmd_left;
  logic [`ADDR_W-1:0]        addr_q;
  logic [ROW_W+BANK_W-1:0]   open_page;     // {row, bank} of the last ACTV
  logic                      refresh_ack;
  logic                      refresh_due;
  logic                      row_hit;
  logic                      accept;
  logic                      load_req;
  sdram_cmd_e                rw_cmd;
  logic [COL_W-1:0]          acc_addr;

  assign command          = cmd_list[0];
  assign change_requested = (cmd_left != 2'd0);
  assign seq_idle         = ~change_requested;
  assign accept           = change_requested && change_possible;
  assign latched          = accept && ((command == READ) || (command == WRTE));

  assign refresh_due = refresh_ack ^ refresh_strobe;  // strobe toggled since last ack
  assign load_req    = seq_idle && !refresh_due && do_act;
  assign rw_cmd      = sel_req.we ? WRTE : READ;
  assign row_hit     = page_active && (sel_req.addr[`ADDR_W-1:COL_W] == open_page);

  always_comb
  begin
    case (command)
      ACTV:       acc_addr = COL_W'(addr_q[`ADDR_W-1 -: ROW_W]);
      READ, WRTE: acc_addr = addr_q[COL_W-1:0];
      default:    acc_addr = '0;
    endcase
  end

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      cmd_left    <= 2'd0;
      cmd_list    <= '{NOOP, NOOP, NOOP};
      refresh_ack <= refresh_strobe;
    end
    else if (change_requested)
    begin
      if (change_possible)
      begin
        cmd_left    <= cmd_left - 2'd1;  // step the list
        cmd_list[0] <= cmd_list[1];
        cmd_list[1] <= cmd_list[2];
        cmd_list[2] <= NOOP;
      end
    end
    else if (refresh_due)
    begin
      refresh_ack <= refresh_strobe;
      cmd_left    <= 2'd2;
      cmd_list    <= '{PRCH, ARSR, NOOP};
    end
    else if (do_act)
    begin
      if (row_hit)
      begin
        cmd_left <= 2'd1;  // page already open
        cmd_list <= '{rw_cmd, NOOP, NOOP};
      end
      else
      begin
        cmd_left <= 2'd3;
        cmd_list <= '{PRCH, ACTV, rw_cmd};
      end
    end
  end

  always_ff @(posedge CLK)
  begin
    if (load_req)
    begin
      addr_q <= sel_req.addr;
    end
    if (accept && (command == ACTV))
    begin
      open_page <= addr_q[`ADDR_W-1:COL_W];
    end
  end

  // command register, PRCH goes out on the tracker's pulse
  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      mem_cmd.cmd  <= NOOP;
      mem_cmd.bank <= '0;
      mem_cmd.addr <= '0;
    end
    else if (accept && (command != PRCH))
    begin
      mem_cmd.cmd  <= command;
      mem_cmd.bank <= addr_q[COL_W +: BANK_W];
      mem_cmd.addr <= acc_addr;
    end
    else if (clock_prch)
    begin
      mem_cmd.cmd  <= PRCH;
      mem_cmd.addr <= 13'h0400;  // A10 high, all banks
    end
    else
    begin
      mem_cmd.cmd <= NOOP;
    end
  end

endmodule

`default_nettype wire

// File: rtl/sdram_data_path.sv
`timescale 1ns/1ns
`default_nettype none

`include "sdram_defs.svh"

module sdram_data_path (
  input  wire logic               CLK,
  input  wire logic               RST,
  input  wire logic               latched,
  input  wire logic               we,
  input  wire logic [`DATA_W-1:0] wdata,
  output logic [`DATA_W-1:0]      dq_out,
  output logic                    dq_oe,
  input  wire logic [`DATA_W-1:0] dq_in,
  output logic                    rd_valid,
  output logic [`DATA_W-1:0]      rd_data
);

  // bit k is set k+1 cycles after a read latch
  logic [`RD_LAT-1:0] rd_strobe;

  assign rd_valid = rd_strobe[`RD_LAT-1];

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      dq_oe     <= 1'b0;
      rd_strobe <= '0;
    end
    else
    begin
      dq_oe     <= latched && we;  // same cycle as WRTE on the pins
      rd_strobe <= {rd_strobe[`RD_LAT-2:0], latched && !we};
    end
  end

  always_ff @(posedge CLK)
  begin
    if (latched && we)
    begin
      dq_out <= wdata;
    end
    // bit 0 lines up with READ on the pins, device answers CAS_LAT later
    if (rd_strobe[`CAS_LAT])
    begin
      rd_data <= dq_in;
    end
  end

endmodule

`default_nettype wire

// File: rtl/client_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

`include "sdram_defs.svh"

module client_arbiter (
  input  wire logic                         CLK,
  input  wire logic                         RST,
  input  wire logic [1:0]                   req_valid,
  input  wire sdram_pkg::client_req_t [1:0] req,
  input  wire logic                         seq_idle,
  input  wire logic                         latched_any,
  output logic [1:0]                        latched,
  output logic                              do_act,
  output sdram_pkg::client_req_t            sel_req,
  input  wire logic                         rd_valid,
  input  wire logic [`DATA_W-1:0]           rd_data,
  output sdram_pkg::rd_resp_t               rd_resp
);

  logic               hold;     // a grant waits for its latch
  logic               gnt_id;
  logic               rr_ptr;   // client with priority next
  logic               pick;
  logic               sel_id;
  logic [`RD_LAT-1:0] id_pipe;  // ids of reads in flight

  assign pick    = req_valid[rr_ptr] ? rr_ptr : ~rr_ptr;
  assign sel_id  = hold ? gnt_id : pick;
  assign do_act  = hold || (seq_idle && (|req_valid));
  assign sel_req = req[sel_id];
  assign latched = {latched_any && gnt_id, latched_any && !gnt_id};

  assign rd_resp.valid = rd_valid;
  assign rd_resp.id    = id_pipe[`RD_LAT-1];
  assign rd_resp.rdata = rd_data;

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      hold   <= 1'b0;
      gnt_id <= 1'b0;
      rr_ptr <= 1'b0;
    end
    else if (hold)
    begin
      if (latched_any)
      begin
        hold <= 1'b0;  // release and pick again next cycle
      end
    end
    else if (seq_idle && (|req_valid))
    begin
      hold   <= 1'b1;
      gnt_id <= pick;
      rr_ptr <= ~pick;
    end
  end

  // grant id delayed by RD_LAT to line up with rd_valid
  always_ff @(posedge CLK)
  begin
    id_pipe <= {id_pipe[`RD_LAT-2:0], gnt_id};
  end

endmodule

`default_nettype wire

// File: rtl/refresh_timer.sv
`timescale 1ns/1ns
`default_nettype none

`include "sdram_defs.svh"

module refresh_timer (
  input  wire logic CLK,
  input  wire logic RST,
  output logic      refresh_strobe
);

  localparam int CNT_W = $clog2(`REFRESH_PERIOD);

  logic [CNT_W-1:0] cnt;

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      cnt            <= '0;
      refresh_strobe <= 1'b0;
    end
    else if (cnt == CNT_W'(`REFRESH_PERIOD - 1))
    begin
      cnt            <= '0;
      refresh_strobe <= ~refresh_strobe;  // sequencer acks by level compare
    end
    else
    begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: rtl/sdram_ctrl_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "sdram_defs.svh"

module sdram_ctrl_top (
  input  wire logic                         CLK,
  input  wire logic                         RST,
  input  wire logic [1:0]                   req_valid,
  input  wire sdram_pkg::client_req_t [1:0] req,
  output logic [1:0]                        latched,
  output sdram_pkg::rd_resp_t               rd_resp,
  output sdram_pkg::mem_cmd_t               mem_cmd,
  output logic [`DATA_W-1:0]                dq_out,
  output logic                              dq_oe,
  input  wire logic [`DATA_W-1:0]           dq_in
);

  import sdram_pkg::*;

  client_req_t        sel_req;
  sdram_cmd_e         command;
  logic               do_act;
  logic               seq_idle;
  logic               seq_latched;
  logic               change_requested;
  logic               change_possible;
  logic               clock_prch;
  logic               page_active;
  logic               refresh_strobe;
  logic               rd_valid;
  logic [`DATA_W-1:0] rd_data;

  client_arbiter client_arbiter_inst (
    .CLK         (CLK),
    .RST         (RST),
    .req_valid   (req_valid),
    .req         (req),
    .seq_idle    (seq_idle),
    .latched_any (seq_latched),
    .latched     (latched),
    .do_act      (do_act),
    .sel_req     (sel_req),
    .rd_valid    (rd_valid),
    .rd_data     (rd_data),
    .rd_resp     (rd_resp)
  );

  sdram_sequencer sdram_sequencer_inst (
    .CLK              (CLK),
    .RST              (RST),
    .do_act           (do_act),
    .sel_req          (sel_req),
    .refresh_strobe   (refresh_strobe),
    .change_possible  (change_possible),
    .clock_prch       (clock_prch),
    .page_active      (page_active),
    .command          (command),
    .change_requested (change_requested),
    .seq_idle         (seq_idle),
    .latched          (seq_latched),
    .mem_cmd          (mem_cmd)
  );

  // state is only needed inside the tracker
  sdram_timing sdram_timing_inst (
    .CLK              (CLK),
    .RST              (RST),
    .change_requested (change_requested),
    .command          (command),
    .change_possible  (change_possible),
    .state            (),
    .clock_prch       (clock_prch),
    .page_active      (page_active)
  );

  sdram_data_path sdram_data_path_inst (
    .CLK      (CLK),
    .RST      (RST),
    .latched  (seq_latched),
    .we       (sel_req.we),
    .wdata    (sel_req.wdata),
    .dq_out   (dq_out),
    .dq_oe    (dq_oe),
    .dq_in    (dq_in),
    .rd_valid (rd_valid),
    .rd_data  (rd_data)
  );

  refresh_timer refresh_timer_inst (
    .CLK            (CLK),
    .RST            (RST),
    .refresh_strobe (refresh_strobe)
  );

endmodule

`default_nettype wire

// File: bench/sdram_model.sv
`timescale 1ns/1ns
`default_nettype none

`include "sdram_defs.svh"

module sdram_model (
  input  wire logic                CLK,
  input  wire logic                RST,
  input  wire sdram_pkg::mem_cmd_t mem_cmd,
  input  wire logic [`DATA_W-1:0]  dq_out,
  input  wire logic                dq_oe,
  output logic [`DATA_W-1:0]       dq_in,
  output int                       violations,
  output int                       actv_count,
  output int                       arsr_count
);

  import sdram_pkg::*;

  logic [`DATA_W-1:0] mem [logic [`ADDR_W-1:0]];
  logic [`DATA_W-1:0] cas_pipe [`CAS_LAT];  // last stage drives dq_in
  logic               row_open;
  logic [11:0]        open_row;
  logic [`ADDR_W-1:0] acc_addr;
  sdram_cmd_e         last_cmd;
  int                 last_cycle;
  int                 cycle;

  assign acc_addr = {open_row, mem_cmd.bank, mem_cmd.addr};
  assign dq_in    = cas_pipe[`CAS_LAT-1];

  // power-up contents, different for every address
  function automatic logic [`DATA_W-1:0] fill_word(logic [`ADDR_W-1:0] a);
    return 32'ha5000000 ^ {5'd0, a};
  endfunction

  function automatic int min_gap(sdram_cmd_e prev, sdram_cmd_e next);
    if ((prev == next) && ((next == READ) || (next == WRTE)))
      return 1;  // burst continuation
    case (prev)
      ACTV:    return `WAIT_ACTV;
      ARSR:    return `WAIT_ARSR;
      default: return `WAIT_OTHER;
    endcase
  endfunction

  task automatic flag(string msg);
    violations = violations + 1;
    $display("ERROR %0t: memory model saw %s", $time, msg);
  endtask

  always @(posedge CLK)
  begin
    if (!RST)
    begin
      row_open   = 1'b0;
      open_row   = '0;
      last_cmd   = NOOP;
      last_cycle = 0;
      cycle      = 0;
      violations = 0;
      actv_count = 0;
      arsr_count = 0;
      for (int k = 0; k < `CAS_LAT; k++)
        cas_pipe[k] <= '0;
    end
    else
    begin
      cycle = cycle + 1;
      cas_pipe[0] <= '0;
      for (int k = 1; k < `CAS_LAT; k++)
        cas_pipe[k] <= cas_pipe[k-1];
      if (dq_oe && (mem_cmd.cmd != WRTE))
        flag("data driven without WRTE");
      if (mem_cmd.cmd != NOOP)
      begin
        if ((last_cmd != NOOP) && ((cycle - last_cycle) < min_gap(last_cmd, mem_cmd.cmd)))
          flag("a command sooner than its wait");
        case (mem_cmd.cmd)
          ACTV:
          begin
            if (row_open)
              flag("ACTV on an open page");
            row_open   = 1'b1;
            open_row   = mem_cmd.addr[11:0];
            actv_count = actv_count + 1;
          end
          PRCH: row_open = 1'b0;  // all banks
          ARSR:
          begin
            if (last_cmd != PRCH)
              flag("ARSR without PRCH before it");
            arsr_count = arsr_count + 1;
          end
          READ:
          begin
            if (!row_open)
              flag("READ without an open row");
            cas_pipe[0] <= mem.exists(acc_addr) ? mem[acc_addr] : fill_word(acc_addr);
          end
          WRTE:
          begin
            if (!row_open)
              flag("WRTE without an open row");
            if (!dq_oe)
              flag("WRTE without write data");
            else
              mem[acc_addr] = dq_out;
          end
          default: flag("an unknown command");
        endcase
        last_cmd   = mem_cmd.cmd;
        last_cycle = cycle;
      end
    end
  end

endmodule

`default_nettype wire

// File: bench/sdram_ctrl_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "sdram_defs.svh"

module sdram_ctrl_tb;

  import sdram_pkg::*;

  localparam int N_PER = 300;              // transactions per client
  localparam int LIMIT = 2 * N_PER * 60;   // cycles

  typedef struct packed {
    logic [`DATA_W-1:0] word;
    logic [31:0]        due;   // cycle of the expected rd_valid
  } pend_t;

  logic               CLK;
  logic               RST;
  logic [1:0]         req_valid;
  client_req_t [1:0]  req;
  logic [1:0]         latched;
  rd_resp_t           rd_resp;
  mem_cmd_t           mem_cmd;
  logic [`DATA_W-1:0] dq_out;
  logic [`DATA_W-1:0] dq_in;
  logic               dq_oe;
  int                 violations;
  int                 actv_count;
  int                 arsr_count;

  logic [31:0]        rng;
  logic [`DATA_W-1:0] ref_mem [logic [`ADDR_W-1:0]];
  pend_t              pend_q [2][$];  // expected words per client
  int                 issued [2];
  int                 lat_cnt [2];
  int                 last_id;
  int                 cycle;
  int                 err_cnt;
  int                 actv_pred;
  int                 exp_refresh;
  logic               page_known;
  logic [13:0]        last_page;     // {row, bank}
  logic               go;
  logic               cmp_id;
  pend_t              cmp_exp;

  sdram_ctrl_top sdram_ctrl_top_inst (
    .CLK       (CLK),
    .RST       (RST),
    .req_valid (req_valid),
    .req       (req),
    .latched   (latched),
    .rd_resp   (rd_resp),
    .mem_cmd   (mem_cmd),
    .dq_out    (dq_out),
    .dq_oe     (dq_oe),
    .dq_in     (dq_in)
  );

  sdram_model sdram_model_inst (
    .CLK        (CLK),
    .RST        (RST),
    .mem_cmd    (mem_cmd),
    .dq_out     (dq_out),
    .dq_oe      (dq_oe),
    .dq_in      (dq_in),
    .violations (violations),
    .actv_count (actv_count),
    .arsr_count (arsr_count)
  );

  function automatic logic [31:0] xorshift(logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // last written word, or the device's power-up pattern
  function automatic logic [`DATA_W-1:0] ref_read(logic [`ADDR_W-1:0] a);
    if (ref_mem.exists(a))
      return ref_mem[a];
    return 32'ha5000000 ^ {5'd0, a};
  endfunction

  function automatic logic all_done();
    return (lat_cnt[0] == N_PER) && (lat_cnt[1] == N_PER) &&
           (pend_q[0].size() == 0) && (pend_q[1].size() == 0);
  endfunction

  task automatic new_request(int i);
    client_req_t c;
    rng = xorshift(rng);
    c.addr = {10'd0, rng[1:0], 2'd0, 10'd0, rng[4:2]};  // 4 rows, 8 columns
    c.we   = rng[5];
    rng = xorshift(rng);
    c.wdata = rng;
    req[i]       <= c;
    req_valid[i] <= 1'b1;
    issued[i]    = issued[i] + 1;
  endtask

  task automatic record_latch(int i);
    client_req_t c;
    pend_t       p;
    c = req[i];
    lat_cnt[i] = lat_cnt[i] + 1;
    if (req_valid == 2'b11)
    begin
      assert (last_id != i)
      else
      begin
        err_cnt++;
        $display("ERROR %0t: client %0d latched twice in a row", $time, i);
      end
    end
    last_id = i;
    if (!page_known || (c.addr[`ADDR_W-1:13] != last_page))
      actv_pred++;  // page change needs ACTV
    page_known = 1'b1;
    last_page  = c.addr[`ADDR_W-1:13];
    if (c.we)
      ref_mem[c.addr] = c.wdata;
    else
    begin
      p.word = ref_read(c.addr);
      p.due  = cycle + `RD_LAT;
      pend_q[i].push_back(p);
    end
  endtask

  initial
  begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  always @(posedge CLK)
  begin
    if (RST)
      cycle <= cycle + 1;
  end

  // quiet bus between reset and the first request
  always @(posedge CLK)
  begin
    if (RST && !go)
    begin
      assert ((mem_cmd.cmd == NOOP) && (latched == 2'b00) && !rd_resp.valid && !dq_oe)
      else
      begin
        err_cnt++;
        $display("ERROR %0t: activity on the outputs before any request", $time);
      end
    end
  end

  always @(posedge CLK)
  begin
    if (RST && go)
    begin
      if (mem_cmd.cmd == ARSR)
        page_known = 1'b0;  // refresh closes the page
      for (int i = 0; i < 2; i++)
      begin
        if (latched[i])
        begin
          record_latch(i);
          if (issued[i] < N_PER)
            new_request(i);
          else
            req_valid[i] <= 1'b0;
        end
      end
    end
  end

  always @(posedge CLK)
  begin
    if (RST && rd_resp.valid)
    begin
      cmp_id = rd_resp.id;
      assert (pend_q[cmp_id].size() > 0)
      else
      begin
        err_cnt++;
        $display("ERROR %0t: read data for client %0d with no read pending", $time, cmp_id);
      end
      if (pend_q[cmp_id].size() > 0)
      begin
        cmp_exp = pend_q[cmp_id].pop_front();
        assert (rd_resp.rdata == cmp_exp.word)
        else
        begin
          err_cnt++;
          $display("ERROR %0t: client %0d read %h, expected %h", $time, cmp_id,
                   rd_resp.rdata, cmp_exp.word);
        end
        assert (cycle == cmp_exp.due)
        else
        begin
          err_cnt++;
          $display("ERROR %0t: client %0d read at cycle %0d, expected cycle %0d", $time,
                   cmp_id, cycle, cmp_exp.due);
        end
      end
    end
  end

  initial
  begin
    RST        = 1'b0;
    req_valid  = 2'b00;
    req        = '0;
    go         = 1'b0;
    rng        = 32'h49a93561;
    cycle      = 0;
    err_cnt    = 0;
    actv_pred  = 0;
    page_known = 1'b0;
    last_page  = '0;
    last_id    = -1;
    issued     = '{0, 0};
    lat_cnt    = '{0, 0};
    repeat (10) @(posedge CLK);
    RST <= 1'b1;
    repeat (8) @(posedge CLK);
    go <= 1'b1;
    new_request(0);
    new_request(1);
    while (!all_done() && (cycle < LIMIT))
      @(negedge CLK);
    if (cycle >= LIMIT)
    begin
      err_cnt++;
      $display("timeout: requests still open after %0d cycles", LIMIT);
    end
    else
    begin
      exp_refresh = cycle / `REFRESH_PERIOD;
      assert (actv_count == actv_pred)
      else
      begin
        err_cnt++;
        $display("ERROR %0t: %0d ACTV on the bus, %0d predicted", $time, actv_count, actv_pred);
      end
      assert ((arsr_count >= exp_refresh - 1) && (arsr_count <= exp_refresh + 1))
      else
      begin
        err_cnt++;
        $display("ERROR %0t: %0d ARSR in %0d cycles", $time, arsr_count, cycle);
      end
    end
    $display("errors: %0d check, %0d model (%0d ACTV, %0d ARSR, %0d cycles)", err_cnt,
             violations, actv_count, arsr_count, cycle);
    if ((err_cnt == 0) && (violations == 0))
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: sdram_ctrl.f
+incdir+rtl
rtl/sdram_pkg.sv
rtl/sdram_timing.sv
rtl/sdram_sequencer.sv
rtl/sdram_data_path.sv
rtl/client_arbiter.sv
rtl/refresh_timer.sv
rtl/sdram_ctrl_top.sv
bench/sdram_model.sv
bench/sdram_ctrl_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --timing --assert -Wno-fatal
TOP       = sdram_ctrl_tb
FILELIST  = sdram_ctrl.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = >>> PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
